// File: include/uart_rx_config.svh
`ifndef UART_RX_CONFIG_SVH
`define UART_RX_CONFIG_SVH

// fixed frame format, 8 data bits to match the rx FSM
`define UART_RX_DATA_BITS 8

// clocks per serial bit, keep it even so the half-bit point is exact
`define UART_RX_CLKS_PER_BIT 16

`endif

// File: hw/uart_rx_pkg.sv
`include "uart_rx_config.svh"

package uart_rx_pkg;

    typedef logic [`UART_RX_DATA_BITS-1:0] rx_data_t;                  // one received byte
    typedef logic [$clog2(`UART_RX_CLKS_PER_BIT + 1)-1:0] bit_count_t; // bit-period counter

    // receive FSM, states in line order
    typedef enum logic [3:0] {
        RX_IDLE       = 4'd0,
        RX_START_BIT  = 4'd1,
        RX_DATA_BIT_0 = 4'd2,
        RX_DATA_BIT_1 = 4'd3,
        RX_DATA_BIT_2 = 4'd4,
        RX_DATA_BIT_3 = 4'd5,
        RX_DATA_BIT_4 = 4'd6,
        RX_DATA_BIT_5 = 4'd7,
        RX_DATA_BIT_6 = 4'd8,
        RX_DATA_BIT_7 = 4'd9,
        RX_PARITY_BIT = 4'd10,
        RX_STOP_BIT   = 4'd11
    } rx_state_t;

    typedef struct packed {
        rx_data_t data;
        logic     parity_error; // even parity mismatch
        logic     frame_error;  // stop bit sampled low
    } rx_frame_t;

endpackage

// File: hw/rx_sampler.sv
`timescale 1ns/100ps
`include "uart_rx_config.svh"

module rx_sampler (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    input  logic line_idle,
    output logic start_detected,
    output logic sampling_strobe,
    output logic sampled_bit
);

    localparam uart_rx_pkg::bit_count_t HALF_BIT =
        uart_rx_pkg::bit_count_t'(`UART_RX_CLKS_PER_BIT / 2 - 1);
    localparam uart_rx_pkg::bit_count_t FULL_BIT =
        uart_rx_pkg::bit_count_t'(`UART_RX_CLKS_PER_BIT - 1);

    logic [1:0]              rx_sync;    // two-flop synchronizer
    logic                    line_prev;  // synchronized line, one cycle back
    logic                    armed_fall; // falling edge seen while idle
    uart_rx_pkg::bit_count_t bit_count;

    assign start_detected = ~rx_sync[1];
    assign armed_fall     = line_prev & ~rx_sync[1] & line_idle;

    // a strobe on the restart cycle would see the new start bit too early
    assign sampling_strobe = (bit_count == '0) & ~armed_fall;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync   <= 2'b11; // line idles high
            line_prev <= 1'b1;
            bit_count <= FULL_BIT;
        end else begin
            rx_sync   <= {rx_sync[0], rx};
            line_prev <= rx_sync[1];
            if (armed_fall) begin
                bit_count <= HALF_BIT; // first strobe lands mid start bit
            end else if (bit_count == '0) begin
                bit_count <= FULL_BIT;
            end else begin
                bit_count <= bit_count - 1'b1;
            end
        end
    end

    // held until the next strobe
    always_ff @(posedge clk) begin
        if (sampling_strobe) begin
            sampled_bit <= rx_sync[1];
        end
    end

endmodule

// File: hw/rx_state.sv
`timescale 1ns/100ps

module rx_state (
    input  logic clk,
    input  logic reset,
    input  logic start_detected,
    input  logic sampling_strobe,
    output logic line_idle,
    output logic data_is_available,
    output logic is_parity_stage,
    output logic data_is_valid
);

    uart_rx_pkg::rx_state_t state;

    assign line_idle = (state == uart_rx_pkg::RX_IDLE); // arms the edge detector

    // stage flags trail the state by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            data_is_available <= 1'b0;
            is_parity_stage   <= 1'b0;
            data_is_valid     <= 1'b0;
        end else begin
            data_is_available <= (state >= uart_rx_pkg::RX_DATA_BIT_0) &&
                                 (state <= uart_rx_pkg::RX_DATA_BIT_7);
            is_parity_stage   <= (state == uart_rx_pkg::RX_PARITY_BIT);
            data_is_valid     <= (state == uart_rx_pkg::RX_STOP_BIT); // frame complete
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= uart_rx_pkg::RX_IDLE;
        end else if (sampling_strobe) begin
            case (state)
                uart_rx_pkg::RX_IDLE: begin
                    // still low at mid start bit, so not a glitch
                    if (start_detected) begin
                        state <= uart_rx_pkg::RX_START_BIT;
                    end
                end
                uart_rx_pkg::RX_START_BIT: begin
                    state <= uart_rx_pkg::RX_DATA_BIT_0;
                end
                uart_rx_pkg::RX_DATA_BIT_0,
                uart_rx_pkg::RX_DATA_BIT_1,
                uart_rx_pkg::RX_DATA_BIT_2,
                uart_rx_pkg::RX_DATA_BIT_3,
                uart_rx_pkg::RX_DATA_BIT_4,
                uart_rx_pkg::RX_DATA_BIT_5,
                uart_rx_pkg::RX_DATA_BIT_6: begin
                    state <= uart_rx_pkg::rx_state_t'(state + 4'd1); // next data bit
                end
                uart_rx_pkg::RX_DATA_BIT_7: begin
                    state <= uart_rx_pkg::RX_PARITY_BIT;
                end
                uart_rx_pkg::RX_PARITY_BIT: begin
                    state <= uart_rx_pkg::RX_STOP_BIT;
                end
                uart_rx_pkg::RX_STOP_BIT: begin
                    state <= uart_rx_pkg::RX_IDLE;
                end
                default: begin
                    state <= uart_rx_pkg::RX_IDLE; // unused encodings
                end
            endcase
        end
    end

endmodule

// File: hw/rx_frame_capture.sv
`timescale 1ns/100ps
`include "uart_rx_config.svh"

module rx_frame_capture (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sampling_strobe,
    input  logic                   sampled_bit,
    input  logic                   data_is_available,
    input  logic                   is_parity_stage,
    input  logic                   data_is_valid,
    output logic                   rx_valid,
    output uart_rx_pkg::rx_frame_t rx_frame
);

    logic [1:0]            strobe_dly; // strobe pipeline
    logic                  take_bit;
    logic                  valid_prev;
    logic                  frame_done;
    logic                  parity_acc; // xor of data bits so far
    logic                  parity_bad;
    uart_rx_pkg::rx_data_t shift_reg;

    // the flags settle one cycle after the state, which moves on the strobe,
    // so the sample is taken once the flag for that bit is up
    assign take_bit   = strobe_dly[1];
    assign frame_done = data_is_valid & ~valid_prev; // stop stage entered

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_dly <= 2'b00;
            valid_prev <= 1'b0;
            parity_acc <= 1'b0;
            parity_bad <= 1'b0;
            rx_valid   <= 1'b0;
            rx_frame   <= '0;
        end else begin
            strobe_dly <= {strobe_dly[0], sampling_strobe};
            valid_prev <= data_is_valid;
            rx_valid   <= frame_done;

            // idle and start stages clear the running parity
            if (!data_is_available && !is_parity_stage && !data_is_valid) begin
                parity_acc <= 1'b0;
            end else if (take_bit && data_is_available) begin
                parity_acc <= parity_acc ^ sampled_bit;
            end

            if (take_bit && is_parity_stage) begin
                parity_bad <= sampled_bit ^ parity_acc; // even parity
            end

            if (frame_done) begin
                rx_frame.data         <= shift_reg;
                rx_frame.parity_error <= parity_bad;
                rx_frame.frame_error  <= ~sampled_bit; // stop bit must be high
            end
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (take_bit && data_is_available) begin
            shift_reg <= {sampled_bit, shift_reg[`UART_RX_DATA_BITS-1:1]};
        end
    end

endmodule

// File: hw/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx,       // async serial in, idles high
    output logic                   rx_valid,
    output uart_rx_pkg::rx_frame_t rx_frame
);

    logic start_detected;
    logic sampling_strobe;
    logic sampled_bit;
    logic line_idle;
    logic data_is_available;
    logic is_parity_stage;
    logic data_is_valid;

    rx_sampler i_rx_sampler (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx),
        .line_idle       (line_idle),
        .start_detected  (start_detected),
        .sampling_strobe (sampling_strobe),
        .sampled_bit     (sampled_bit)
    );

    rx_state i_rx_state (
        .clk               (clk),
        .reset             (reset),
        .start_detected    (start_detected),
        .sampling_strobe   (sampling_strobe),
        .line_idle         (line_idle),
        .data_is_available (data_is_available),
        .is_parity_stage   (is_parity_stage),
        .data_is_valid     (data_is_valid)
    );

    rx_frame_capture i_rx_frame_capture (
        .clk               (clk),
        .reset             (reset),
        .sampling_strobe   (sampling_strobe),
        .sampled_bit       (sampled_bit),
        .data_is_available (data_is_available),
        .is_parity_stage   (is_parity_stage),
        .data_is_valid     (data_is_valid),
        .rx_valid          (rx_valid),
        .rx_frame          (rx_frame)
    );

endmodule

// File: verification/uart_rx_checker.sv
`timescale 1ns/100ps

module uart_rx_checker (
    input logic clk,
    input logic reset,
    input logic rx_valid,
    input logic sampling_strobe,
    input logic data_is_available,
    input logic is_parity_stage,
    input logic data_is_valid
);

    int assert_failures = 0; // failed assertions so far

    a_valid_single_cycle: assert property (
        @(posedge clk) disable iff (reset) rx_valid |=> !rx_valid
    ) else begin
        assert_failures++;
        $error("rx_valid high for two consecutive cycles");
    end

    a_no_valid_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !rx_valid
    ) else begin
        assert_failures++;
        $error("rx_valid high in the first cycle after reset");
    end

    // the FSM sits in one stage at a time
    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (reset)
            $onehot0({data_is_available, is_parity_stage, data_is_valid})
    ) else begin
        assert_failures++;
        $error("more than one stage flag high");
    end

    a_strobe_single_cycle: assert property (
        @(posedge clk) disable iff (reset) sampling_strobe |=> !sampling_strobe
    ) else begin
        assert_failures++;
        $error("sampling_strobe high for two consecutive cycles");
    end

endmodule

bind uart_rx uart_rx_checker i_uart_rx_checker (
    .clk               (clk),
    .reset             (reset),
    .rx_valid          (rx_valid),
    .sampling_strobe   (sampling_strobe),
    .data_is_available (data_is_available),
    .is_parity_stage   (is_parity_stage),
    .data_is_valid     (data_is_valid)
);

// File: verification/uart_rx_tb.sv
`timescale 1ns/100ps
`include "uart_rx_config.svh"

module uart_rx_tb;

    localparam int CLKS_PER_BIT = `UART_RX_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 12 * CLKS_PER_BIT; // start, data, parity, stop, idle
    // 24 frames, the glitch window, 20 idle bits, reset plus margin
    localparam int TIMEOUT_CYCLES = 25 * FRAME_CYCLES + 20 * CLKS_PER_BIT + 880;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   rx;
    logic                   rx_valid;
    uart_rx_pkg::rx_frame_t rx_frame;

    uart_rx_pkg::rx_frame_t expected_q[$]; // frames on the line, oldest first
    int frames_sent = 0;
    int frames_seen = 0;
    int error_count = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycle_count = 0;

    uart_rx i_uart_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles waiting for frames", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    // compare each reported frame with the oldest one sent
    always @(posedge clk) begin
        uart_rx_pkg::rx_frame_t expected;
        if (rx_valid) begin
            frames_seen++;
            if (expected_q.size() == 0) begin
                $display("unexpected rx_valid at %0t ns with no frame on the line", $time);
                error_count++;
            end else begin
                expected = expected_q.pop_front();
                assert (rx_frame.data == expected.data) else begin
                    $display("ERROR at %0t ns: rx_frame.data expected %02h got %02h",
                             $time, expected.data, rx_frame.data);
                    error_count++;
                end
                assert (rx_frame.parity_error == expected.parity_error) else begin
                    $display("ERROR at %0t ns: rx_frame.parity_error expected %0b got %0b",
                             $time, expected.parity_error, rx_frame.parity_error);
                    error_count++;
                end
                assert (rx_frame.frame_error == expected.frame_error) else begin
                    $display("ERROR at %0t ns: rx_frame.frame_error expected %0b got %0b",
                             $time, expected.frame_error, rx_frame.frame_error);
                    error_count++;
                end
            end
        end
    end

    task automatic drive_bit(input logic value, input int cycles);
        rx <= value;
        repeat (cycles) @(posedge clk);
    endtask

    // one frame plus an idle bit, or a short low pulse and a frame's length of idle line
    task automatic send_frame(input uart_rx_pkg::rx_data_t data, input bit flip_parity,
                              input bit stop_low, input bit glitch);
        uart_rx_pkg::rx_frame_t expected;
        logic                   parity;
        int                     i;
        if (glitch) begin
            drive_bit(1'b0, CLKS_PER_BIT / 4);
            drive_bit(1'b1, FRAME_CYCLES - CLKS_PER_BIT / 4); // long enough for a false frame
        end else begin
            parity                = (^data) ^ flip_parity; // even parity unless flipped
            expected.data         = data;
            expected.parity_error = flip_parity;
            expected.frame_error  = stop_low;
            expected_q.push_back(expected);
            frames_sent++;
            drive_bit(1'b0, CLKS_PER_BIT); // start
            for (i = 0; i < `UART_RX_DATA_BITS; i++) begin
                drive_bit(data[i], CLKS_PER_BIT); // lsb first
            end
            drive_bit(parity, CLKS_PER_BIT);
            drive_bit(~stop_low, CLKS_PER_BIT);
            drive_bit(1'b1, CLKS_PER_BIT); // idle gap
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        while (frames_seen < frames_sent) begin
            @(posedge clk);
        end
        assert (frames_seen == frames_sent) else begin
            $display("%s: %0d rx_valid pulses seen for %0d frames sent",
                     name, frames_seen, frames_sent);
            error_count++;
        end
        if (error_count == errors_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: FAIL", name);
        end
    endtask

    initial begin
        int errors_before;
        int value;
        int i;
        int checker_errors;
        void'($urandom(6386));
        reset = 1'b1;
        rx    = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        errors_before = error_count;
        drive_bit(1'b1, 20 * CLKS_PER_BIT);
        finish_test("idle line after reset", errors_before);

        errors_before = error_count;
        for (i = 0; i < 20; i++) begin
            if (i == 0) begin
                value = 'h00;
            end else if (i == 1) begin
                value = 'hFF;
            end else if (i == 2) begin
                value = 'h55;
            end else begin
                value = $urandom();
            end
            send_frame(value[7:0], 1'b0, 1'b0, 1'b0);
        end
        finish_test("twenty clean bytes", errors_before);

        errors_before = error_count;
        value = $urandom();
        send_frame(value[7:0], 1'b1, 1'b0, 1'b0);
        finish_test("inverted parity bit", errors_before);

        errors_before = error_count;
        value = $urandom();
        send_frame(value[7:0], 1'b0, 1'b1, 1'b0);
        send_frame(8'hA5, 1'b0, 1'b0, 1'b0); // clean frame after the bad stop
        finish_test("stop bit low then recovery", errors_before);

        errors_before = error_count;
        send_frame(8'h00, 1'b0, 1'b0, 1'b1);
        assert (frames_seen == frames_sent) else begin
            $display("glitch on the idle line was reported as a frame");
            error_count++;
        end
        send_frame(8'h3C, 1'b0, 1'b0, 1'b0);
        finish_test("quarter bit glitch", errors_before);

        checker_errors = i_uart_rx.i_uart_rx_checker.assert_failures;
        if (checker_errors != 0) begin
            $display("%0d protocol assertions failed in the checker", checker_errors);
        end
        $display("summary: %0d tests ok, %0d tests failing, %0d errors",
                 tests_ok, tests_bad, error_count + checker_errors);
        if (error_count == 0 && checker_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
hw/uart_rx_pkg.sv
hw/rx_sampler.sv
hw/rx_state.sv
hw/rx_frame_capture.sv
hw/uart_rx.sv
verification/uart_rx_checker.sv
verification/uart_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the UART receiver testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=uart_rx_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    -f sim.f \
    --top-module uart_rx_tb \
    --Mdir "${BUILD_DIR}" \
    -o "${SIM_BIN}"
build_status=$?
if [ ${build_status} -ne 0 ]; then
    echo "verilator build failed with status ${build_status}"
    exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
run_status=$?
cat "${LOG_FILE}"
if [ ${run_status} -ne 0 ]; then
    echo "simulation exited with status ${run_status}"
    exit 1
fi

if grep -qx "test passed" "${LOG_FILE}"; then
    exit 0
fi
echo "pass message not found in ${LOG_FILE}"
exit 1
